//--- hdl/fixed_point_pkg.sv
/*
 * fixed-point word format and multiplier request types
 */
package fixed_point_pkg;

  // ==============================
  // word format
  // ==============================

  // bits in one fixed-point word
  localparam int WORD_WIDTH = 16;

  // one word, read as signed or unsigned by the SIGN parameter of the user
  typedef logic [WORD_WIDTH-1:0] fixed_t;

  // full-width product before the binary-point shift
  typedef logic [2*WORD_WIDTH-1:0] wide_t;

  // ==============================
  // multiplier request
  // ==============================

  // one multiplication, a times b
  typedef struct packed {
    fixed_t a;
    fixed_t b;
  } mult_operands_t;

endpackage

//--- hdl/conv_pkg.sv
/*
 * convolution vector types
 * shared by the convolution block and the top level
 */
package conv_pkg;

  import fixed_point_pkg::*;

  // ==============================
  // vector geometry
  // ==============================

  // elements per vector
  localparam int ARRAY_LENGTH = 8;

  // ==============================
  // vector type
  // ==============================

  // element 0 sits in the least significant word
  typedef struct packed {
    fixed_t [ARRAY_LENGTH-1:0] elem;
  } conv_vec_t;

endpackage

//--- hdl/iterative_multiplier.sv
/*
 * iterative shift-and-add fixed-point multiplier
 * one multiplier bit per cycle, valid/ready on request and response
 */
`timescale 1ns/1ps

module iterative_multiplier import fixed_point_pkg::*; #(
  parameter int DECIMAL_BITS = 8,
  parameter bit SIGN         = 1
) (
  input  logic           clk,
  input  logic           reset,
  input  mult_operands_t req,
  input  logic           req_val,
  output logic           req_rdy,
  output fixed_t         product,
  output logic           resp_val,
  input  logic           resp_rdy
);

  // counter has to reach WORD_WIDTH
  localparam int CNT_W = $clog2(WORD_WIDTH + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUSY,
    S_HOLD
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] bit_cnt;
  logic             accept;

  // operand magnitudes and result sign
  fixed_t mag_a;
  fixed_t mag_b;
  logic   neg_in;

  // iteration registers
  wide_t  acc;
  wide_t  mcand;
  fixed_t mplier;
  logic   neg_q;

  // final scaling
  wide_t  scaled;
  fixed_t trunc;
  fixed_t result;

  assign req_rdy  = (state == S_IDLE);
  assign resp_val = (state == S_HOLD);
  assign accept   = req_val && req_rdy;

  // ==============================
  // operand conditioning
  // ==============================

  always_comb begin
    mag_a  = req.a;
    mag_b  = req.b;
    neg_in = 1'b0;
    if (SIGN) begin
      // most negative word maps onto itself, read as unsigned
      if (req.a[WORD_WIDTH-1]) begin
        mag_a = -req.a;
      end
      if (req.b[WORD_WIDTH-1]) begin
        mag_b = -req.b;
      end
      neg_in = req.a[WORD_WIDTH-1] ^ req.b[WORD_WIDTH-1];
    end
  end

  // binary-point shift, truncate, then restore the sign
  always_comb begin
    scaled = acc >> DECIMAL_BITS;
    trunc  = scaled[WORD_WIDTH-1:0];
    result = neg_q ? -trunc : trunc;
  end

  // ==============================
  // control
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            state   <= S_BUSY;
            bit_cnt <= CNT_W'(WORD_WIDTH);
          end
        end
        S_BUSY: begin
          // one extra cycle at zero to register the product
          if (bit_cnt == '0) begin
            state <= S_HOLD;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        S_HOLD: begin
          if (resp_rdy) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // ==============================
  // datapath
  // ==============================

  always_ff @(posedge clk) begin
    if (accept) begin
      acc    <= '0;
      mcand  <= wide_t'(mag_a);
      mplier <= mag_b;
      neg_q  <= neg_in;
    end else if (state == S_BUSY) begin
      if (bit_cnt != '0) begin
        // add the shifted multiplicand for each set multiplier bit
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end else begin
        product <= result;
      end
    end
  end

endmodule

//--- hdl/convolution_block.sv
/*
 * convolution block, lane i multiplies input i by filter ARRAY_LENGTH-1-i
 * idle/calc/done FSM over an array of iterative multipliers
 */
`timescale 1ns/1ps

module convolution_block import fixed_point_pkg::*, conv_pkg::*; #(
  parameter int DECIMAL_BITS = 8,
  parameter bit SIGN         = 1
) (
  input  logic      clk,
  input  logic      reset,
  input  conv_vec_t in_vec,
  input  logic      in_val,
  output logic      in_rdy,
  input  conv_vec_t filter_vec,
  input  logic      filter_val,
  output logic      filter_rdy,
  output conv_vec_t out_vec,
  output logic      out_val,
  input  logic      out_rdy
);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  state_t state;
  state_t next_state;

  logic                    accept;
  logic                    lane_resp_rdy;
  logic [ARRAY_LENGTH-1:0] lane_rdy;
  logic [ARRAY_LENGTH-1:0] lane_resp_val;
  mult_operands_t          lane_req [ARRAY_LENGTH];
  fixed_t                  lane_product [ARRAY_LENGTH];

  // ==============================
  // handshakes
  // ==============================

  // input and filter only transfer as a pair
  assign accept     = (state == IDLE) && in_val && filter_val && (&lane_rdy);
  assign in_rdy     = (state == IDLE);
  assign filter_rdy = (state == IDLE);
  assign out_val    = (state == DONE);

  // lanes release their products with the output transfer
  assign lane_resp_rdy = out_val && out_rdy;

  // ==============================
  // FSM
  // ==============================

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (accept) begin
          next_state = CALC;
        end
      end
      CALC: begin
        if (&lane_resp_val) begin
          next_state = DONE;
        end
      end
      DONE: begin
        if (out_rdy) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // ==============================
  // multiplier lanes
  // ==============================

  for (genvar i = 0; i < ARRAY_LENGTH; i++) begin : g_lane
    // reversed filter pairing
    assign lane_req[i] = '{a: in_vec.elem[i], b: filter_vec.elem[ARRAY_LENGTH-1-i]};

    iterative_multiplier #(
      .DECIMAL_BITS(DECIMAL_BITS),
      .SIGN        (SIGN)
    ) mult (
      .clk     (clk),
      .reset   (reset),
      .req     (lane_req[i]),
      .req_val (accept),
      .req_rdy (lane_rdy[i]),
      .product (lane_product[i]),
      .resp_val(lane_resp_val[i]),
      .resp_rdy(lane_resp_rdy)
    );
  end

  // gather lane products into the output vector
  always_comb begin
    for (int k = 0; k < ARRAY_LENGTH; k++) begin
      out_vec.elem[k] = lane_product[k];
    end
  end

endmodule

//--- hdl/convolution_top.sv
/*
 * convolution top level
 * fixes the fixed-point format and wraps the convolution block
 */
`timescale 1ns/1ps

module convolution_top import conv_pkg::*; #(
  // binary point position
  parameter int DECIMAL_BITS = 8,
  // two's complement operands when set
  parameter bit SIGN         = 1
) (
  input  logic      clk,
  input  logic      reset,

  // input vector
  input  conv_vec_t in_vec,
  input  logic      in_val,
  output logic      in_rdy,

  // filter vector
  input  conv_vec_t filter_vec,
  input  logic      filter_val,
  output logic      filter_rdy,

  // result vector
  output conv_vec_t out_vec,
  output logic      out_val,
  input  logic      out_rdy
);

  // ==============================
  // convolution core
  // ==============================

  convolution_block #(
    .DECIMAL_BITS(DECIMAL_BITS),
    .SIGN        (SIGN)
  ) conv0 (
    .clk       (clk),
    .reset     (reset),
    .in_vec    (in_vec),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .filter_vec(filter_vec),
    .filter_val(filter_val),
    .filter_rdy(filter_rdy),
    .out_vec   (out_vec),
    .out_val   (out_val),
    .out_rdy   (out_rdy)
  );

endmodule

//--- tb/conv_ref.svh
/*
 * convolution testbench reference model
 * xorshift generator, expected products and the value check
 */
`ifndef CONV_REF_SVH
`define CONV_REF_SVH

// wide enough for a whole vector or any scalar status
typedef logic [$bits(conv_vec_t)-1:0] check_word_t;

// one xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] s;
  s = state;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

// magnitudes, full product, binary-point shift, truncation, sign
function automatic fixed_t reference_product(input fixed_t a, input fixed_t b,
                                             input bit signed_mode, input int frac_bits);
  longint full;
  longint mag_a;
  longint mag_b;
  longint word;
  bit     negate;
  full   = longint'(1) << WORD_WIDTH;
  mag_a  = longint'(a);
  mag_b  = longint'(b);
  negate = 1'b0;
  if (signed_mode) begin
    // 0x8000 gives 32768 here, read as unsigned
    if (a[WORD_WIDTH-1]) mag_a = full - mag_a;
    if (b[WORD_WIDTH-1]) mag_b = full - mag_b;
    negate = (a[WORD_WIDTH-1] != b[WORD_WIDTH-1]);
  end
  word = ((mag_a * mag_b) >> frac_bits) % full;
  if (negate) begin
    word = (full - word) % full;
  end
  return fixed_t'(word);
endfunction

// element i pairs with filter element ARRAY_LENGTH-1-i
function automatic conv_vec_t reference_conv(input conv_vec_t in_v, input conv_vec_t filt_v,
                                             input bit signed_mode, input int frac_bits);
  conv_vec_t res;
  for (int i = 0; i < ARRAY_LENGTH; i++) begin
    res.elem[i] = reference_product(in_v.elem[i], filt_v.elem[ARRAY_LENGTH-1-i],
                                    signed_mode, frac_bits);
  end
  return res;
endfunction

task automatic check_value(input string name, input check_word_t expected,
                           input check_word_t actual);
  if (expected !== actual) begin
    $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    stop_with_failure();
  end
endtask

`endif

//--- tb/tb_convolution.sv
/*
 * convolution testbench
 * directed and random vector pairs checked against a reference model
 */
`timescale 1ns/1ps

module tb_convolution import fixed_point_pkg::*, conv_pkg::*; ();

  localparam int FRAC_BITS   = 8;
  localparam bit SIGNED_MODE = 1;
  localparam int WAIT_LIMIT  = 200;

  logic      clk = 1'b0;
  logic      reset;
  conv_vec_t in_vec;
  logic      in_val;
  logic      in_rdy;
  conv_vec_t filter_vec;
  logic      filter_val;
  logic      filter_rdy;
  conv_vec_t out_vec;
  logic      out_val;
  logic      out_rdy;

  // scoreboard state, written by the comparison process
  conv_vec_t   expected_q[$];
  int          in_count = 0;
  int          out_count = 0;
  int          cycle_count = 0;
  int          accept_cycle = 0;
  bit          busy = 1'b0;
  bit          hold_pending = 1'b0;
  bit          out_val_seen = 1'b0;
  conv_vec_t   held_vec;
  string       test_name = "reset";
  logic [31:0] rand_state;

  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  `include "conv_ref.svh"

  convolution_top #(
    .DECIMAL_BITS(FRAC_BITS),
    .SIGN        (SIGNED_MODE)
  ) dut0 (
    .clk       (clk),
    .reset     (reset),
    .in_vec    (in_vec),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .filter_vec(filter_vec),
    .filter_val(filter_val),
    .filter_rdy(filter_rdy),
    .out_vec   (out_vec),
    .out_val   (out_val),
    .out_rdy   (out_rdy)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // ==============================
  // stimulus helpers
  // ==============================

  function automatic logic [31:0] next_random();
    rand_state = xorshift32(rand_state);
    return rand_state;
  endfunction

  // zero, most negative and -1 show up often
  function automatic fixed_t random_word();
    logic [31:0] r;
    r = next_random();
    case (r[3:0])
      4'h0: return '0;
      4'h1: return 16'h8000;
      4'h2: return 16'hFFFF;
      default: return r[31:16];
    endcase
  endfunction

  function automatic conv_vec_t random_vec();
    conv_vec_t v;
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      v.elem[i] = random_word();
    end
    return v;
  endfunction

  // vals are already up, wait for the pair to go across
  task automatic wait_for_pair_transfer();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(in_rdy && filter_rdy)) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: DUT never took the input and filter pair");
        stop_with_failure();
      end
      @(negedge clk);
    end
    @(posedge clk);
    in_val     <= 1'b0;
    filter_val <= 1'b0;
  endtask

  task automatic send_pair(input conv_vec_t a, input conv_vec_t f);
    @(posedge clk);
    in_vec     <= a;
    filter_vec <= f;
    in_val     <= 1'b1;
    filter_val <= 1'b1;
    wait_for_pair_transfer();
  endtask

  // one side alone for a few cycles, then the other joins
  task automatic offer_alone(input conv_vec_t a, input conv_vec_t f, input bit input_first);
    @(posedge clk);
    in_vec     <= a;
    filter_vec <= f;
    in_val     <= input_first;
    filter_val <= !input_first;
    repeat (5) begin
      @(negedge clk);
      check_value({test_name, " in_rdy"}, check_word_t'(1'b1), check_word_t'(in_rdy));
      check_value({test_name, " filter_rdy"}, check_word_t'(1'b1), check_word_t'(filter_rdy));
      check_value({test_name, " out_val"}, check_word_t'(1'b0), check_word_t'(out_val));
    end
    @(posedge clk);
    in_val     <= 1'b1;
    filter_val <= 1'b1;
    wait_for_pair_transfer();
  endtask

  task automatic drain(input bit random_ready);
    int          waited;
    logic [31:0] r;
    waited = 0;
    while (out_count != in_count) begin
      @(posedge clk);
      r = next_random();
      out_rdy <= random_ready ? r[4] : 1'b1;
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: result vector did not arrive");
        stop_with_failure();
      end
    end
  endtask

  // ==============================
  // comparison process
  // ==============================

  always @(negedge clk) begin
    if (!reset) begin
      if (busy) begin
        check_value({test_name, " in_rdy busy"}, '0, check_word_t'(in_rdy));
        check_value({test_name, " filter_rdy busy"}, '0, check_word_t'(filter_rdy));
      end
      // held output must not move
      if (hold_pending) begin
        check_value({test_name, " out_val held"}, check_word_t'(1'b1), check_word_t'(out_val));
        check_value({test_name, " out_vec held"}, held_vec, out_vec);
      end
      if (out_val && !out_val_seen) begin
        check_value({test_name, " latency"}, check_word_t'(WORD_WIDTH + 2),
                    check_word_t'(cycle_count - accept_cycle));
      end
      if (in_val && filter_val && in_rdy && filter_rdy) begin
        expected_q.push_back(reference_conv(in_vec, filter_vec, SIGNED_MODE, FRAC_BITS));
        in_count++;
        accept_cycle = cycle_count + 1;
        busy = 1'b1;
      end
      if (out_val && out_rdy) begin
        if (expected_q.size() == 0) begin
          $display("output transfer with no pending pair");
          stop_with_failure();
        end
        check_value(test_name, expected_q.pop_front(), out_vec);
        out_count++;
        busy = 1'b0;
      end
      hold_pending = out_val && !out_rdy;
      held_vec     = out_vec;
      out_val_seen = out_val;
    end
  end

  // ==============================
  // test sequence
  // ==============================

  initial begin
    conv_vec_t a;
    conv_vec_t f;
    reset      = 1'b1;
    in_vec     = '0;
    in_val     = 1'b0;
    filter_vec = '0;
    filter_val = 1'b0;
    out_rdy    = 1'b1;
    rand_state = 32'd19;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("reset out_val", '0, check_word_t'(out_val));
    check_value("reset in_rdy", check_word_t'(1'b1), check_word_t'(in_rdy));
    check_value("reset filter_rdy", check_word_t'(1'b1), check_word_t'(filter_rdy));

    // 1.0 filter first, then small integers
    test_name = "directed";
    for (int k = 0; k < ARRAY_LENGTH; k++) begin
      a.elem[k] = fixed_t'((k + 1) << FRAC_BITS);
      f.elem[k] = fixed_t'(1 << FRAC_BITS);
    end
    send_pair(a, f);
    for (int k = 0; k < ARRAY_LENGTH; k++) begin
      f.elem[k] = fixed_t'((k + 1) << FRAC_BITS);
    end
    send_pair(a, f);
    drain(1'b0);

    test_name = "random signed";
    repeat (200) begin
      a = random_vec();
      f = random_vec();
      send_pair(a, f);
    end
    drain(1'b0);

    test_name = "lone offer";
    offer_alone(random_vec(), random_vec(), 1'b1);
    drain(1'b0);
    offer_alone(random_vec(), random_vec(), 1'b0);
    drain(1'b0);

    test_name = "back-pressure";
    repeat (30) begin
      a = random_vec();
      f = random_vec();
      send_pair(a, f);
      drain(1'b1);
    end

    test_name = "back-to-back";
    @(posedge clk);
    out_rdy <= 1'b1;
    repeat (20) begin
      a = random_vec();
      f = random_vec();
      send_pair(a, f);
    end
    drain(1'b0);

    // back in idle once the last result has gone out
    @(negedge clk);
    if (out_val || !in_rdy || !filter_rdy) begin
      $display("DUT did not return to idle after the last result");
      stop_with_failure();
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

//--- sources.f
+incdir+tb
hdl/fixed_point_pkg.sv
hdl/conv_pkg.sv
hdl/iterative_multiplier.sv
hdl/convolution_block.sv
hdl/convolution_top.sv
tb/tb_convolution.sv

//--- Makefile
# Verilator build and run for the convolution testbench

VERILATOR ?= verilator
TOP       ?= tb_convolution
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

FILELIST := sources.f
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard tb/*.svh)
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a listed source, a header or the list changes
$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
